// ==== list.f ====
src/snake_pkg.sv
src/key_sync.sv
src/game_ctrl.sv
src/snake_body.sv
src/food_gen.sv
src/vga_scan.sv
src/snake_game_top.sv
testbench/tb_snake_game.sv

// ==== testbench/tb_snake_game.sv ====
`timescale 1ns/1ps

module tb_snake_game;

	localparam int MOVE_PERIOD = 40;

	logic clk;
	logic rst;
	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic hsync;
	logic vsync;
	logic [11:0] rgb;
	logic [5:0] head_x;
	logic [5:0] head_y;
	logic [6:0] cube_num;
	logic [7:0] score;
	logic [1:0] game_status;

	// Reference model
	logic [1:0] m_status;
	logic [1:0] m_dir;
	logic [1:0] m_pend;
	logic [5:0] mx [16];
	logic [5:0] my [16];
	int m_len;
	int m_score;
	logic [5:0] fx;
	logic [5:0] fy;
	logic [15:0] food_lfsr;
	logic [9:0] scan_h;
	logic [9:0] scan_v;
	logic [9:0] rgb_h;
	logic [9:0] rgb_v;
	bit rgb_ok;
	bit head_chk;
	int head_seen;
	int eats;
	logic [31:0] stim;

	snake_game_top #(.MOVE_PERIOD(MOVE_PERIOD)) snake_game_top_inst (
		.clk(clk), .rst(rst),
		.btn_up(btn_up), .btn_down(btn_down), .btn_left(btn_left), .btn_right(btn_right),
		.hsync(hsync), .vsync(vsync), .rgb(rgb), .head_x(head_x), .head_y(head_y),
		.cube_num(cube_num), .score(score), .game_status(game_status)
	);

	always #50 clk = ~clk;

	// Food LFSR runs every clk from the seed
	always @(posedge clk or negedge rst) begin
		if (!rst)
			food_lfsr <= snake_pkg::FOOD_SEED;
		else
			food_lfsr <= {food_lfsr[14:0], ^(food_lfsr & snake_pkg::FOOD_TAPS)};
	end

	// Scan position, and the position the current rgb belongs to
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			scan_h <= '0;
			scan_v <= '0;
			rgb_h <= '0;
			rgb_v <= '0;
			rgb_ok <= 1'b0;
		end else begin
			rgb_h <= scan_h;
			rgb_v <= scan_v;
			rgb_ok <= 1'b1;
			if (scan_h == 10'd799) begin
				scan_h <= '0;
				scan_v <= (scan_v == 10'd524) ? 10'd0 : scan_v + 10'd1;
			end else begin
				scan_h <= scan_h + 10'd1;
			end
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic take_bit();
		stim = lfsr_next(stim);
		return stim[0];
	endfunction

	function automatic logic [1:0] rand_dir();
		logic [1:0] d;
		d[1] = take_bit();
		d[0] = take_bit();
		return d;
	endfunction

	function automatic bit is_reverse(input logic [1:0] a, input logic [1:0] b);
		return (a == snake_pkg::DIR_UP && b == snake_pkg::DIR_DOWN) ||
			(a == snake_pkg::DIR_DOWN && b == snake_pkg::DIR_UP) ||
			(a == snake_pkg::DIR_LEFT && b == snake_pkg::DIR_RIGHT) ||
			(a == snake_pkg::DIR_RIGHT && b == snake_pkg::DIR_LEFT);
	endfunction

	// Packed as {x, y}
	function automatic logic [11:0] next_cell(input logic [1:0] d, input logic [5:0] x,
		input logic [5:0] y);
		case (d)
			snake_pkg::DIR_UP: return {x, y - 6'd1};
			snake_pkg::DIR_DOWN: return {x, y + 6'd1};
			snake_pkg::DIR_LEFT: return {x - 6'd1, y};
			default: return {x + 6'd1, y};
		endcase
	endfunction

	// Border or a body cell that stays after the tail moves on
	function automatic bit blocked(input logic [11:0] c);
		bit hit;
		hit = (c[11:6] == 6'd0) || (c[11:6] == snake_pkg::GRID_W - 6'd1) ||
			(c[5:0] == 6'd0) || (c[5:0] == snake_pkg::GRID_H - 6'd1);
		for (int i = 0; i < m_len - 1; i++) begin
			if (mx[i] == c[11:6] && my[i] == c[5:0])
				hit = 1'b1;
		end
		return hit;
	endfunction

	function automatic bit safe(input logic [1:0] d);
		logic [1:0] p;
		p = is_reverse(d, m_dir) ? m_pend : d;
		return !blocked(next_cell(p, mx[0], my[0]));
	endfunction

	function automatic logic [1:0] pick_safe(input logic [1:0] d);
		for (int k = 0; k < 4; k++) begin
			if (!is_reverse(2'(k), m_dir) && safe(2'(k)))
				return 2'(k);
		end
		return d;
	endfunction

	function automatic logic [1:0] toward_food();
		if (fx > mx[0])
			return snake_pkg::DIR_RIGHT;
		else if (fx < mx[0])
			return snake_pkg::DIR_LEFT;
		else if (fy > my[0])
			return snake_pkg::DIR_DOWN;
		return snake_pkg::DIR_UP;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stop_run($sformatf("MISMATCH at %0t: %s is %0h, expected %0h",
				$time, name, actual, expected));
	endtask

	task automatic check_pixel();
		logic [5:0] cx;
		logic [5:0] cy;
		cx = 6'(rgb_h >> snake_pkg::CELL_SHIFT);
		cy = 6'(rgb_v >> snake_pkg::CELL_SHIFT);
		if (rgb_ok) begin
			// Sync pulses are active low
			check_value("hsync", hsync,
				(rgb_h < snake_pkg::H_SYNC_BEG || rgb_h >= snake_pkg::H_SYNC_END));
			check_value("vsync", vsync,
				(rgb_v < snake_pkg::V_SYNC_BEG || rgb_v >= snake_pkg::V_SYNC_END));
			if (rgb_h >= snake_pkg::SCAN_W || rgb_v >= snake_pkg::SCAN_H)
				check_value("rgb", rgb, snake_pkg::COLOR_NONE);
			else if (cx == 6'd0 || cx == snake_pkg::GRID_W - 6'd1 ||
				cy == 6'd0 || cy == snake_pkg::GRID_H - 6'd1)
				check_value("rgb", rgb, snake_pkg::COLOR_WALL);
			else if (head_chk && cx == mx[0] && cy == my[0]) begin
				check_value("rgb", rgb, snake_pkg::COLOR_HEAD);
				head_seen++;
			end
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
		check_pixel();
	endtask

	task automatic press_button(input logic [1:0] d);
		btn_up = (d == snake_pkg::DIR_UP);
		btn_down = (d == snake_pkg::DIR_DOWN);
		btn_left = (d == snake_pkg::DIR_LEFT);
		btn_right = (d == snake_pkg::DIR_RIGHT);
		step();
		step();
		{btn_up, btn_down, btn_left, btn_right} = 4'b0000;
	endtask

	task automatic restart_model();
		for (int i = 0; i < 16; i++) begin
			mx[i] = snake_pkg::START_X - 6'(i);
			my[i] = snake_pkg::START_Y;
		end
		m_status = snake_pkg::ST_RESTART;
		m_len = 3;
		m_score = 0;
		m_dir = snake_pkg::DIR_RIGHT;
		m_pend = snake_pkg::DIR_RIGHT;
		fx = snake_pkg::FOOD_START_X;
		fy = snake_pkg::FOOD_START_Y;
	endtask

	task automatic check_state();
		check_value("game_status", game_status, m_status);
		check_value("head_x", head_x, mx[0]);
		check_value("head_y", head_y, my[0]);
		check_value("cube_num", cube_num, m_len);
		check_value("score", score, m_score);
	endtask

	task automatic model_move();
		logic [11:0] c;
		bit hit;
		m_dir = m_pend;
		c = next_cell(m_dir, mx[0], my[0]);
		hit = blocked(c);
		for (int i = 15; i > 0; i--) begin
			mx[i] = mx[i-1];
			my[i] = my[i-1];
		end
		mx[0] = c[11:6];
		my[0] = c[5:0];
		if (hit)
			m_status = snake_pkg::ST_DEAD;
		// Food is compared after every head update, even on a hit
		if (mx[0] == fx && my[0] == fy) begin
			if (m_len < 16)
				m_len++;
			m_score++;
			eats++;
			fx = 6'd1 + 6'(food_lfsr[4:0]); // LFSR value of the cycle after the move
			fy = 6'd2 + 6'(food_lfsr[8:5]);
		end
	endtask

	task automatic wait_move();
		logic [5:0] ox;
		logic [5:0] oy;
		int n;
		ox = head_x;
		oy = head_y;
		n = 0;
		while (head_x == ox && head_y == oy) begin
			if (n == 2 * MOVE_PERIOD + 10)
				stop_run("Timeout while waiting for the snake head to move");
			step();
			n++;
		end
	endtask

	// Mode 0 random turns, 1 chase the food, 2 go straight
	task automatic play_move(input int mode);
		logic [1:0] d;
		bit do_press;
		do_press = (mode != 2);
		d = m_pend;
		if (mode == 0) begin
			d = rand_dir();
			if (take_bit() && safe(m_pend))
				do_press = 1'b0;
			else if (!safe(d))
				d = pick_safe(d);
		end else if (mode == 1) begin
			d = toward_food();
			if (is_reverse(d, m_dir) || !safe(d))
				d = pick_safe(d);
		end
		if (do_press) begin
			if (!is_reverse(d, m_dir))
				m_pend = d;
			press_button(d);
		end
		wait_move();
		model_move();
		step();
		step(); // Length and score settle two cycles after the move
		check_state();
	endtask

	task automatic start_game();
		logic [1:0] d;
		int n;
		d = rand_dir();
		if (d == snake_pkg::DIR_LEFT)
			d = snake_pkg::DIR_UP;
		m_pend = d;
		press_button(d);
		n = 0;
		while (game_status != snake_pkg::ST_PLAY) begin
			if (n == 20)
				stop_run("Timeout while waiting for the game to start after a press");
			step();
			n++;
		end
		m_status = snake_pkg::ST_PLAY;
	endtask

	task automatic finish_death();
		int n;
		n = 0;
		while (game_status != snake_pkg::ST_RESTART) begin
			if (n == (int'(snake_pkg::DEAD_FLASHES) + 2) * MOVE_PERIOD)
				stop_run("Timeout while waiting for the game to return to restart");
			step();
			n++;
		end
		step();
		step();
		restart_model();
		check_state();
	endtask

	initial begin
		int n;
		clk = 1'b0;
		rst = 1'b0;
		{btn_up, btn_down, btn_left, btn_right} = 4'b0000;
		stim = 32'h0f983bf9;
		eats = 0;
		head_chk = 1'b0;
		head_seen = 0;
		restart_model();
		repeat (4) step();
		rst = 1'b1;
		step();
		check_state();

		start_game();
		for (int i = 0; i < 25; i++) begin
			if (m_status == snake_pkg::ST_DEAD) begin
				finish_death();
				start_game();
			end
			play_move(0);
		end

		for (int i = 0; i < 400 && eats < 3; i++) begin
			if (m_status == snake_pkg::ST_DEAD) begin
				finish_death();
				start_game();
			end
			play_move(1);
		end
		if (eats < 3)
			stop_run("The snake did not reach the food three times");

		if (m_status == snake_pkg::ST_DEAD) begin
			finish_death();
			start_game();
		end
		for (int i = 0; i < 45 && m_status != snake_pkg::ST_DEAD; i++)
			play_move(2);
		if (m_status != snake_pkg::ST_DEAD)
			stop_run("The snake did not reach a wall");
		finish_death();

		// Start just before the scan crosses the head cell
		n = 0;
		while (!(scan_h == 10'd150 && scan_v == 10'(snake_pkg::START_Y) * 10'd16)) begin
			if (n == 430000)
				stop_run("Timeout while waiting for the scan to reach the head row");
			step();
			n++;
		end
		start_game();
		head_chk = 1'b1;
		repeat (30) step();
		head_chk = 1'b0;
		check_value("head_seen", head_seen, 16);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== src/snake_game_top.sv ====
`timescale 1ns/1ps

module snake_game_top #(
	parameter int MOVE_PERIOD = 40
) (
	input logic clk,
	input logic rst,
	input logic btn_up,
	input logic btn_down,
	input logic btn_left,
	input logic btn_right,
	output logic hsync,
	output logic vsync,
	output logic [11:0] rgb,
	output logic [5:0] head_x,
	output logic [5:0] head_y,
	output logic [6:0] cube_num,
	output logic [7:0] score,
	output logic [1:0] game_status
);

	logic up_press;
	logic down_press;
	logic left_press;
	logic right_press;
	logic any_press;
	logic move_tick;
	logic die_flash;
	logic hit_wall;
	logic hit_body;
	logic add_cube;
	logic [5:0] food_x;
	logic [5:0] food_y;
	logic [9:0] x_pos;
	logic [9:0] y_pos;
	logic [2:0] cell_class;

	assign any_press = up_press | down_press | left_press | right_press;

	key_sync key_sync_inst (
		.clk(clk), .rst(rst),
		.btn_up(btn_up), .btn_down(btn_down), .btn_left(btn_left), .btn_right(btn_right),
		.up_press(up_press), .down_press(down_press),
		.left_press(left_press), .right_press(right_press)
	);

	game_ctrl #(.MOVE_PERIOD(MOVE_PERIOD)) game_ctrl_inst (
		.clk(clk), .rst(rst),
		.any_press(any_press), .hit_wall(hit_wall), .hit_body(hit_body),
		.add_cube(add_cube), .game_status(game_status), .move_tick(move_tick),
		.die_flash(die_flash), .score(score)
	);

	snake_body snake_body_inst (
		.clk(clk), .rst(rst),
		.up_press(up_press), .down_press(down_press),
		.left_press(left_press), .right_press(right_press),
		.move_tick(move_tick), .add_cube(add_cube), .die_flash(die_flash),
		.game_status(game_status), .x_pos(x_pos), .y_pos(y_pos),
		.food_x(food_x), .food_y(food_y), .head_x(head_x), .head_y(head_y),
		.cube_num(cube_num), .hit_wall(hit_wall), .hit_body(hit_body),
		.cell_class(cell_class)
	);

	food_gen food_gen_inst (
		.clk(clk), .rst(rst),
		.game_status(game_status), .head_x(head_x), .head_y(head_y),
		.move_tick(move_tick), .food_x(food_x), .food_y(food_y), .add_cube(add_cube)
	);

	vga_scan vga_scan_inst (
		.clk(clk), .rst(rst),
		.cell_class(cell_class), .x_pos(x_pos), .y_pos(y_pos),
		.hsync(hsync), .vsync(vsync), .rgb(rgb)
	);

endmodule

// ==== src/vga_scan.sv ====
`timescale 1ns/1ps

module vga_scan (
	input logic clk,
	input logic rst,
	input logic [2:0] cell_class,
	output logic [9:0] x_pos,
	output logic [9:0] y_pos,
	output logic hsync,
	output logic vsync,
	output logic [11:0] rgb
);

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic visible;
	logic [11:0] color;

	assign x_pos = h_cnt;
	assign y_pos = v_cnt;
	assign visible = (h_cnt < snake_pkg::SCAN_W) && (v_cnt < snake_pkg::SCAN_H);

	always_comb begin
		case (cell_class)
			snake_pkg::CLS_HEAD: color = snake_pkg::COLOR_HEAD;
			snake_pkg::CLS_BODY: color = snake_pkg::COLOR_BODY;
			snake_pkg::CLS_WALL: color = snake_pkg::COLOR_WALL;
			snake_pkg::CLS_FOOD: color = snake_pkg::COLOR_FOOD;
			default: color = snake_pkg::COLOR_NONE;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			rgb <= snake_pkg::COLOR_NONE;
		end else begin
			if (h_cnt == snake_pkg::H_TOTAL - 10'd1) begin
				h_cnt <= '0;
				v_cnt <= (v_cnt == snake_pkg::V_TOTAL - 10'd1) ? '0 : v_cnt + 10'd1;
			end else begin
				h_cnt <= h_cnt + 10'd1;
			end
			// Aligned with the colour of the same position
			hsync <= !(h_cnt >= snake_pkg::H_SYNC_BEG && h_cnt < snake_pkg::H_SYNC_END);
			vsync <= !(v_cnt >= snake_pkg::V_SYNC_BEG && v_cnt < snake_pkg::V_SYNC_END);
			rgb <= visible ? color : snake_pkg::COLOR_NONE;
		end
	end

endmodule

// ==== src/food_gen.sv ====
`timescale 1ns/1ps

module food_gen (
	input logic clk,
	input logic rst,
	input logic [1:0] game_status,
	input logic [5:0] head_x,
	input logic [5:0] head_y,
	input logic move_tick,
	output logic [5:0] food_x,
	output logic [5:0] food_y,
	output logic add_cube
);

	logic [15:0] lfsr;
	logic feedback;
	logic tick_d;

	assign feedback = ^(lfsr & snake_pkg::FOOD_TAPS);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			lfsr <= snake_pkg::FOOD_SEED;
		else
			lfsr <= {lfsr[14:0], feedback}; // Steps every clk
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tick_d <= 1'b0;
			add_cube <= 1'b0;
			food_x <= snake_pkg::FOOD_START_X;
			food_y <= snake_pkg::FOOD_START_Y;
		end else begin
			tick_d <= move_tick; // Head is updated by now
			add_cube <= 1'b0;
			if (game_status == snake_pkg::ST_RESTART) begin
				food_x <= snake_pkg::FOOD_START_X;
				food_y <= snake_pkg::FOOD_START_Y;
			end else if (game_status == snake_pkg::ST_PLAY && tick_d &&
				head_x == food_x && head_y == food_y) begin
				add_cube <= 1'b1;
				food_x <= 6'd1 + 6'(lfsr[4:0]);
				food_y <= 6'd2 + 6'(lfsr[8:5]);
			end
		end
	end

endmodule

// ==== src/snake_body.sv ====
`timescale 1ns/1ps

module snake_body (
	input logic clk,
	input logic rst,
	input logic up_press,
	input logic down_press,
	input logic left_press,
	input logic right_press,
	input logic move_tick,
	input logic add_cube,
	input logic die_flash,
	input logic [1:0] game_status,
	input logic [9:0] x_pos,
	input logic [9:0] y_pos,
	input logic [5:0] food_x,
	input logic [5:0] food_y,
	output logic [5:0] head_x,
	output logic [5:0] head_y,
	output logic [6:0] cube_num,
	output logic hit_wall,
	output logic hit_body,
	output logic [2:0] cell_class
);

	localparam int N = snake_pkg::MAX_CELLS;

	logic [1:0] dir;
	logic [1:0] dir_pend;
	logic [5:0] cube_x [N];
	logic [5:0] cube_y [N];
	logic [N-1:0] is_exist;
	logic press_valid;
	logic [1:0] press_dir;
	logic press_rev;
	logic move;
	logic [5:0] next_x;
	logic [5:0] next_y;
	logic next_wall;
	logic next_body;
	logic [5:0] cx;
	logic [5:0] cy;
	logic on_body;

	assign head_x = cube_x[0];
	assign head_y = cube_y[0];
	assign move = (game_status == snake_pkg::ST_PLAY) && move_tick;

	always_comb begin
		press_valid = up_press | down_press | left_press | right_press;
		if (up_press)
			press_dir = snake_pkg::DIR_UP;
		else if (down_press)
			press_dir = snake_pkg::DIR_DOWN;
		else if (left_press)
			press_dir = snake_pkg::DIR_LEFT;
		else
			press_dir = snake_pkg::DIR_RIGHT;
		press_rev = ((press_dir ^ dir) == 2'b01);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			dir <= snake_pkg::DIR_RIGHT;
			dir_pend <= snake_pkg::DIR_RIGHT;
		end else if (game_status == snake_pkg::ST_RESTART) begin
			dir <= snake_pkg::DIR_RIGHT;
			dir_pend <= press_valid ? press_dir : snake_pkg::DIR_RIGHT; // Starting press
		end else if (game_status == snake_pkg::ST_PLAY) begin
			if (move_tick)
				dir <= dir_pend;
			if (press_valid && !press_rev)
				dir_pend <= press_dir;
		end
	end

	// Head step in the direction about to become current
	always_comb begin
		next_x = cube_x[0];
		next_y = cube_y[0];
		case (dir_pend)
			snake_pkg::DIR_UP: next_y = cube_y[0] - 6'd1;
			snake_pkg::DIR_DOWN: next_y = cube_y[0] + 6'd1;
			snake_pkg::DIR_LEFT: next_x = cube_x[0] - 6'd1;
			default: next_x = cube_x[0] + 6'd1;
		endcase
		next_wall = (next_x == 6'd0) || (next_x == snake_pkg::GRID_W - 6'd1) ||
			(next_y == 6'd0) || (next_y == snake_pkg::GRID_H - 6'd1);
		next_body = 1'b0;
		// Cell i moves to slot i+1, the old tail leaves
		for (int i = 0; i < N - 1; i++) begin
			if (is_exist[i+1] && cube_x[i] == next_x && cube_y[i] == next_y)
				next_body = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (game_status == snake_pkg::ST_RESTART) begin
			for (int i = 0; i < N; i++) begin
				cube_x[i] <= snake_pkg::START_X - 6'(i);
				cube_y[i] <= snake_pkg::START_Y;
			end
		end else if (move) begin
			for (int i = N - 1; i > 0; i--) begin
				cube_x[i] <= cube_x[i-1];
				cube_y[i] <= cube_y[i-1];
			end
			cube_x[0] <= next_x;
			cube_y[0] <= next_y;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			is_exist <= N'(7);
			cube_num <= snake_pkg::START_LEN;
			hit_wall <= 1'b0;
			hit_body <= 1'b0;
		end else if (game_status == snake_pkg::ST_RESTART) begin
			is_exist <= N'(7);
			cube_num <= snake_pkg::START_LEN;
			hit_wall <= 1'b0;
			hit_body <= 1'b0;
		end else begin
			hit_wall <= move && next_wall;
			hit_body <= move && next_body;
			// New tail takes the spot the old tail left
			if (add_cube && cube_num < 7'(N)) begin
				is_exist[cube_num[3:0]] <= 1'b1;
				cube_num <= cube_num + 7'd1;
			end
		end
	end

	always_comb begin
		cx = 6'(x_pos >> snake_pkg::CELL_SHIFT);
		cy = 6'(y_pos >> snake_pkg::CELL_SHIFT);
		on_body = 1'b0;
		for (int i = 1; i < N; i++) begin
			if (is_exist[i] && cube_x[i] == cx && cube_y[i] == cy)
				on_body = 1'b1;
		end
		if (cx == 6'd0 || cx == snake_pkg::GRID_W - 6'd1 ||
			cy == 6'd0 || cy == snake_pkg::GRID_H - 6'd1)
			cell_class = snake_pkg::CLS_WALL;
		else if (die_flash && cx == cube_x[0] && cy == cube_y[0])
			cell_class = snake_pkg::CLS_HEAD;
		else if (die_flash && on_body)
			cell_class = snake_pkg::CLS_BODY;
		else if (cx == food_x && cy == food_y)
			cell_class = snake_pkg::CLS_FOOD;
		else
			cell_class = snake_pkg::CLS_NONE;
	end

endmodule

// ==== src/game_ctrl.sv ====
`timescale 1ns/1ps

module game_ctrl #(
	parameter int MOVE_PERIOD = 40
) (
	input logic clk,
	input logic rst,
	input logic any_press,
	input logic hit_wall,
	input logic hit_body,
	input logic add_cube,
	output logic [1:0] game_status,
	output logic move_tick,
	output logic die_flash,
	output logic [7:0] score
);

	localparam int CNT_W = $clog2(MOVE_PERIOD + 1);

	logic [CNT_W-1:0] move_cnt;
	logic [3:0] flash_cnt;
	logic period_end;

	assign period_end = (move_cnt == CNT_W'(MOVE_PERIOD - 1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			game_status <= snake_pkg::ST_RESTART;
			move_cnt <= '0;
			move_tick <= 1'b0;
			die_flash <= 1'b1;
			flash_cnt <= '0;
			score <= '0;
		end else begin
			move_tick <= 1'b0;
			case (game_status)
				snake_pkg::ST_RESTART: begin
					move_cnt <= '0;
					flash_cnt <= '0;
					die_flash <= 1'b1;
					if (any_press)
						game_status <= snake_pkg::ST_PLAY;
				end
				snake_pkg::ST_PLAY: begin
					move_cnt <= period_end ? '0 : move_cnt + 1'b1;
					move_tick <= period_end;
					if (hit_wall || hit_body) begin
						game_status <= snake_pkg::ST_DEAD;
						move_cnt <= '0; // Flash periods start fresh
						move_tick <= 1'b0;
					end
				end
				snake_pkg::ST_DEAD: begin
					move_cnt <= period_end ? '0 : move_cnt + 1'b1;
					if (period_end) begin
						die_flash <= ~die_flash;
						flash_cnt <= flash_cnt + 4'd1;
						if (flash_cnt == snake_pkg::DEAD_FLASHES - 4'd1)
							game_status <= snake_pkg::ST_RESTART;
					end
				end
				default: game_status <= snake_pkg::ST_RESTART;
			endcase

			// A late add_cube can still land right after a hit
			if (game_status == snake_pkg::ST_RESTART)
				score <= '0;
			else if (add_cube)
				score <= score + 8'd1;
		end
	end

endmodule

// ==== src/key_sync.sv ====
`timescale 1ns/1ps

module key_sync (
	input logic clk,
	input logic rst,
	input logic btn_up,
	input logic btn_down,
	input logic btn_left,
	input logic btn_right,
	output logic up_press,
	output logic down_press,
	output logic left_press,
	output logic right_press
);

	logic [3:0] btn_s1;
	logic [3:0] btn_s2;
	logic [3:0] btn_prev;
	logic [3:0] press;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			btn_s1 <= '0;
			btn_s2 <= '0;
			btn_prev <= '0;
			press <= '0;
		end else begin
			btn_s1 <= {btn_up, btn_down, btn_left, btn_right};
			btn_s2 <= btn_s1;
			btn_prev <= btn_s2;
			press <= btn_s2 & ~btn_prev; // Rising edge, one cycle
		end
	end

	assign {up_press, down_press, left_press, right_press} = press;

endmodule

// ==== src/snake_pkg.sv ====
package snake_pkg;

	// Grid in 16-pixel cells
	localparam logic [5:0] GRID_W = 6'd40;
	localparam logic [5:0] GRID_H = 6'd30;
	localparam int CELL_SHIFT = 4;

	localparam logic [9:0] SCAN_W = 10'd640;
	localparam logic [9:0] SCAN_H = 10'd480;
	localparam logic [9:0] H_TOTAL = 10'd800;
	localparam logic [9:0] V_TOTAL = 10'd525;
	localparam logic [9:0] H_SYNC_BEG = 10'd656; // Sync pulses, active low
	localparam logic [9:0] H_SYNC_END = 10'd752;
	localparam logic [9:0] V_SYNC_BEG = 10'd490;
	localparam logic [9:0] V_SYNC_END = 10'd492;

	localparam int MAX_CELLS = 16;
	localparam logic [6:0] START_LEN = 7'd3;

	// Opposite directions differ only in bit 0
	localparam logic [1:0] DIR_UP = 2'b00;
	localparam logic [1:0] DIR_DOWN = 2'b01;
	localparam logic [1:0] DIR_LEFT = 2'b10;
	localparam logic [1:0] DIR_RIGHT = 2'b11;

	localparam logic [1:0] ST_RESTART = 2'b00;
	localparam logic [1:0] ST_DEAD = 2'b01;
	localparam logic [1:0] ST_PLAY = 2'b10;

	localparam logic [2:0] CLS_NONE = 3'd0;
	localparam logic [2:0] CLS_HEAD = 3'd1;
	localparam logic [2:0] CLS_BODY = 3'd2;
	localparam logic [2:0] CLS_WALL = 3'd3;
	localparam logic [2:0] CLS_FOOD = 3'd4;

	localparam logic [5:0] START_X = 6'd10;
	localparam logic [5:0] START_Y = 6'd10;
	localparam logic [5:0] FOOD_START_X = 6'd20;
	localparam logic [5:0] FOOD_START_Y = 6'd15;

	localparam logic [3:0] DEAD_FLASHES = 4'd8;

	localparam logic [15:0] FOOD_SEED = 16'hace1;
	localparam logic [15:0] FOOD_TAPS = 16'hb400; // x^16 + x^14 + x^13 + x^11

	localparam logic [11:0] COLOR_NONE = 12'h000;
	localparam logic [11:0] COLOR_HEAD = 12'h0f0;
	localparam logic [11:0] COLOR_BODY = 12'h0a0;
	localparam logic [11:0] COLOR_WALL = 12'h00f;
	localparam logic [11:0] COLOR_FOOD = 12'hf00;

endpackage
